// ==== src/ppu_settings.svh ====
// frame timing for a 640x480 vga scan
// placement of the 256x240 picture inside the frame
// ppu memory map bases and register reset values
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// vga frame, clocks per line and lines per frame
`define PPU_H_TOTAL          800
`define PPU_V_TOTAL          525
`define PPU_DISPLAY_W        640
`define PPU_DISPLAY_H        480
`define PPU_HSYNC_START      656   // hsync low from here
`define PPU_HSYNC_END        752
`define PPU_VSYNC_START      490   // vsync low on these lines
`define PPU_VSYNC_END        492

// nes picture, always 1x and centred
`define PPU_NES_W            256
`define PPU_NES_H            240
`define PPU_NES_X_OFS        192
`define PPU_NES_Y_OFS        120
`define PPU_BORDER_RGB       12'h888  // grey around the picture

// memory map
`define PPU_PALETTE_PAGE     6'h3F     // vram_a[13:8] for palette ram
`define PPU_NAME_TABLE_BASE  14'h2000
`define PPU_ATTR_TABLE_BASE  14'h23C0
`define PPU_ADDR_BUF_RESET   14'h0200

`endif

// ==== src/ppu_pkg.sv ====
// shared types of the ppu background path
// cpu bus, control fields, scan position, vram claim,
// palette port, background pixel and colour
`default_nettype none

package ppu_pkg;

  typedef struct packed {
    logic [2:0] sel;    // register select, 0x2000 + sel
    logic       ncs;    // chip select, active low
    logic       r_nw;   // 1 = read
    logic [7:0] din;
  } ri_bus_t;

  typedef struct packed {
    logic [1:0] name_tbl;
    logic       addr_incr;    // 0x2007 step, 0 = 1, 1 = 32
    logic       pattern_tbl;
    logic       nvbl_en;
    logic       bg_en;        // from 0x2001 bit 3
  } ppu_ctrl_t;

  typedef struct packed {
    logic [9:0] x;        // picture coords, wrap mod 1024
    logic [9:0] y;
    logic       visible;  // inside 640x480
    logic       border;   // visible but outside the picture
    logic       vblank;
  } scan_pos_t;

  typedef struct packed {
    logic [13:0] addr;
    logic        busy;    // display owns the bus
  } vram_req_t;

  typedef struct packed {
    logic [4:0] addr;
    logic [5:0] wdata;
    logic       we;
  } pal_port_t;

  typedef struct packed {
    logic       show;
    logic [3:0] idx;      // image palette index
  } bg_pixel_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

endpackage

`default_nettype wire

// ==== src/ppu_scan_timing.sv ====
// vga line and frame counters
// raw sync levels, before the output register
// picture coordinates and visible, border, vblank flags
`default_nettype none
`include "ppu_settings.svh"

module ppu_scan_timing
(
  input  wire                clk,
  input  wire                rst,
  output ppu_pkg::scan_pos_t pos,
  output logic               hsync_raw,
  output logic               vsync_raw
);

logic [9:0] h_cnt;   // clock within the line
logic [9:0] v_cnt;   // line within the frame
logic       h_last;
logic       v_last;

assign h_last = (h_cnt == 10'(`PPU_H_TOTAL - 1));
assign v_last = (v_cnt == 10'(`PPU_V_TOTAL - 1));

always_ff @(posedge clk)
begin
  if (rst)
  begin
    h_cnt <= '0;
    v_cnt <= '0;
  end
  else if (h_last)
  begin
    h_cnt <= '0;
    v_cnt <= v_last ? 10'd0 : v_cnt + 10'd1;
  end
  else
    h_cnt <= h_cnt + 10'd1;
end

// sync is active low
assign hsync_raw = !((h_cnt >= `PPU_HSYNC_START) && (h_cnt < `PPU_HSYNC_END));
assign vsync_raw = !((v_cnt >= `PPU_VSYNC_START) && (v_cnt < `PPU_VSYNC_END));

always_comb
begin
  pos.x       = h_cnt - 10'(`PPU_NES_X_OFS);   // wraps left of the picture
  pos.y       = v_cnt - 10'(`PPU_NES_Y_OFS);
  pos.visible = (h_cnt < `PPU_DISPLAY_W) && (v_cnt < `PPU_DISPLAY_H);
  pos.border  = pos.visible && ((pos.x >= `PPU_NES_W) || (pos.y >= `PPU_NES_H));
  pos.vblank  = (pos.y >= `PPU_NES_H);   // lines above and below the picture
end

endmodule

`default_nettype wire

// ==== src/ppu_reg_if.sv ====
// cpu register interface of the ppu
// 0x2000/0x2001 control, 0x2002 status, 0x2006 address,
// 0x2007 buffered data, shared vram bus driver, /vbl
`default_nettype none
`include "ppu_settings.svh"

module ppu_reg_if
(
  input  wire                clk,
  input  wire                rst,
  input  wire ppu_pkg::ri_bus_t   ri,
  input  wire ppu_pkg::scan_pos_t pos,
  input  wire ppu_pkg::vram_req_t bg_req,
  input  wire [7:0]          vram_din,
  input  wire [5:0]          pal_rdata,
  output ppu_pkg::ppu_ctrl_t ctrl,
  output ppu_pkg::pal_port_t pal,
  output logic [7:0]         ri_dout,
  output logic [13:0]        vram_a,
  output logic [7:0]         vram_dout,
  output logic               vram_wr,
  output logic               nvbl
);

// buffered command, bit 0 valid, bit 1 write
localparam logic [1:0] cmd_nop = 2'b00;
localparam logic [1:0] cmd_rd  = 2'b01;
localparam logic [1:0] cmd_wr  = 2'b11;

logic        ncs_q;      // last ncs, for the falling edge
logic        cs_edge;
logic [13:0] addr;       // cpu address counter
logic        addr_hi;    // next 0x2006 write is the high byte
logic [7:0]  dout_q;     // output latch
logic [13:0] addr_buf;   // address of the pending command
logic [7:0]  rd_buf;     // result of the last buffered read
logic [7:0]  wr_buf;
logic [1:0]  cmd;
logic        issue;      // command goes out this cycle
logic        is_pal;
logic [13:0] addr_step;

assign cs_edge   = !ri.ncs && ncs_q;
assign issue     = cmd[0] && !bg_req.busy;
assign is_pal    = (addr_buf[13:8] == `PPU_PALETTE_PAGE);
assign addr_step = ctrl.addr_incr ? 14'd32 : 14'd1;

always_ff @(posedge clk)
begin
  if (rst)
  begin
    ncs_q    <= 1'b1;
    addr     <= '0;
    addr_hi  <= 1'b1;
    dout_q   <= '0;
    addr_buf <= `PPU_ADDR_BUF_RESET;
    rd_buf   <= '0;
    cmd      <= cmd_nop;
    ctrl     <= '0;
  end
  else
  begin
    ncs_q <= ri.ncs;
    if (issue)
      cmd <= cmd_nop;
    if (issue && !cmd[1])   // palette reads come back 6 bits wide
      rd_buf <= is_pal ? {2'b00, pal_rdata} : vram_din;
    if (cs_edge && ri.r_nw)
    begin
      case (ri.sel)
        3'h2: dout_q <= {pos.vblank, 7'h00};   // status
        3'h7:
        begin
          dout_q   <= rd_buf;   // previous read result
          addr_buf <= addr;
          cmd      <= cmd_rd;
          addr     <= addr + addr_step;
        end
        default: ;
      endcase
    end
    else if (cs_edge)
    begin
      case (ri.sel)
        3'h0:
        begin
          ctrl.name_tbl    <= ri.din[1:0];
          ctrl.addr_incr   <= ri.din[2];
          ctrl.pattern_tbl <= ri.din[4];
          ctrl.nvbl_en     <= ri.din[7];
        end
        3'h1: ctrl.bg_en <= ri.din[3];
        3'h6:
        begin
          addr_hi <= !addr_hi;
          addr    <= addr_hi ? {ri.din[5:0], addr[7:0]} : {addr[13:8], ri.din};
        end
        3'h7:
        begin
          addr_buf <= addr;
          cmd      <= cmd_wr;
          addr     <= addr + addr_step;
        end
        default: ;
      endcase
    end
  end
end

// 0x2007 write data
always_ff @(posedge clk)
begin
  if (cs_edge && !ri.r_nw && (ri.sel == 3'h7))
    wr_buf <= ri.din;
end

//////////////////////////////
// bus and outputs
//////////////////////////////
assign vram_a    = bg_req.busy ? bg_req.addr : addr_buf;   // display wins
assign vram_dout = wr_buf;
assign vram_wr   = issue && cmd[1] && !is_pal;
assign pal.addr  = addr_buf[4:0];
assign pal.wdata = wr_buf[5:0];
assign pal.we    = issue && cmd[1] && is_pal;
assign ri_dout   = (!ri.ncs && ri.r_nw) ? dout_q : 8'h00;
assign nvbl      = !(pos.vblank && ctrl.nvbl_en);

endmodule

`default_nettype wire

// ==== src/ppu_bg_fetch.sv ====
// background tile fetcher
// eight-clock tile cycle, slots 0-3 own the vram bus
// ping-pong attribute and pattern buffers, image palette index
`default_nettype none
`include "ppu_settings.svh"

module ppu_bg_fetch
(
  input  wire                clk,
  input  wire                rst,
  input  wire ppu_pkg::scan_pos_t pos,
  input  wire ppu_pkg::ppu_ctrl_t ctrl,
  input  wire [7:0]          vram_din,
  output ppu_pkg::vram_req_t bg_req,
  output ppu_pkg::bg_pixel_t pixel
);

localparam logic [13:0] name_base = `PPU_NAME_TABLE_BASE;
localparam logic [13:0] attr_base = `PPU_ATTR_TABLE_BASE;

logic [4:0] tile_x;
logic [4:0] tile_y;
logic [4:0] next_tile_x;   // wraps 31 -> 0 before the line starts
logic [2:0] fine_x;        // slot within the tile
logic       cur;           // buffer half being shown
logic [7:0] tile_name;     // name of the next tile
logic [7:0] attr [2];
logic [7:0] bit0 [2];
logic [7:0] bit1 [2];
logic [7:0] attr_sh;

assign tile_x      = pos.x[7:3];
assign tile_y      = pos.y[7:3];
assign next_tile_x = tile_x + 5'd1;
assign fine_x      = pos.x[2:0];
assign cur         = tile_x[0];

//////////////////////////////
// fetch slots
//////////////////////////////
assign bg_req.busy = ctrl.bg_en && !pos.vblank && !fine_x[2];

always_comb
begin
  case (fine_x[1:0])
    2'd0: bg_req.addr = {name_base[13:12], ctrl.name_tbl, tile_y, next_tile_x};
    2'd1: bg_req.addr = {attr_base[13:12], ctrl.name_tbl, attr_base[9:6],
                         tile_y[4:2], next_tile_x[4:2]};
    2'd2: bg_req.addr = {1'b0, ctrl.pattern_tbl, tile_name, 1'b0, pos.y[2:0]};  // plane 0
    default: bg_req.addr = {1'b0, ctrl.pattern_tbl, tile_name, 1'b1, pos.y[2:0]};
  endcase
end

always_ff @(posedge clk)
begin
  if (rst)
  begin
    tile_name <= '0;
    attr      <= '{default: '0};
    bit0      <= '{default: '0};
    bit1      <= '{default: '0};
  end
  else if (bg_req.busy)
  begin
    case (fine_x[1:0])
      2'd0: tile_name <= vram_din;
      2'd1: attr[!cur] <= vram_din;   // fill the idle half
      2'd2: bit0[!cur] <= vram_din;
      default: bit1[!cur] <= vram_din;
    endcase
  end
end

//////////////////////////////
// pixel index
//////////////////////////////
// quadrant of the 32x32 attribute area picks two bits
assign attr_sh = attr[cur] >> {tile_y[1], tile_x[1], 1'b0};

assign pixel.show = ctrl.bg_en;
assign pixel.idx  = {attr_sh[1:0], bit1[cur][~fine_x], bit0[cur][~fine_x]};  // msb first

endmodule

`default_nettype wire

// ==== src/ppu_palette.sv ====
// palette stage of the ppu
// 32x6 palette ram with cpu port and display read
// 64-entry system colour table, border and blanking,
// output register for rgb and both syncs
`default_nettype none
`include "ppu_settings.svh"

module ppu_palette
(
  input  wire                 clk,
  input  wire                 rst,
  input  wire ppu_pkg::scan_pos_t pos,
  input  wire ppu_pkg::bg_pixel_t pixel,
  input  wire ppu_pkg::pal_port_t pal,
  input  wire                 hsync_raw,
  input  wire                 vsync_raw,
  output logic [5:0]          pal_rdata,
  output ppu_pkg::rgb_t       rgb,
  output logic                hsync,
  output logic                vsync
);

// approximate nes system colours, index 0x00 to 0x3f
localparam logic [11:0] sys_rgb [64] = '{
  12'h888, 12'h03a, 12'h01b, 12'h409, 12'ha05, 12'hc02, 12'hb00, 12'h810,
  12'h520, 12'h140, 12'h040, 12'h042, 12'h046, 12'h000, 12'h000, 12'h000,
  12'hccc, 12'h07f, 12'h25f, 12'h83f, 12'he2b, 12'hf25, 12'hf20, 12'hd30,
  12'hc60, 12'h380, 12'h080, 12'h085, 12'h09c, 12'h222, 12'h000, 12'h000,
  12'hfff, 12'h0df, 12'h6af, 12'hd8f, 12'hf4f, 12'hf68, 12'hf83, 12'hf91,
  12'hfb2, 12'h9e0, 12'h2f3, 12'h0fa, 12'h0ff, 12'h555, 12'h000, 12'h000,
  12'hfff, 12'haff, 12'hbef, 12'hdae, 12'hfaf, 12'hfab, 12'hfdb, 12'hfea,
  12'hff9, 12'hde9, 12'haea, 12'hafd, 12'h9ff, 12'hddd, 12'h111, 12'h111
};

logic [5:0]  pal_ram [32];   // 0x3F00..0x3F1F, sprite half unused by display
logic [5:0]  sys_idx;
logic [11:0] color;

//////////////////////////////
// palette ram
//////////////////////////////
always_ff @(posedge clk)
begin
  if (pal.we)
    pal_ram[pal.addr] <= pal.wdata;
end

assign pal_rdata = pal_ram[pal.addr];   // cpu side, combinational

// background uses the image half only
assign sys_idx = pixel.show ? pal_ram[{1'b0, pixel.idx}] : 6'h00;

//////////////////////////////
// colour and output register
//////////////////////////////
always_comb
begin
  if (!pos.visible)
    color = 12'h000;                 // blanking
  else if (pos.border)
    color = `PPU_BORDER_RGB;
  else
    color = sys_rgb[sys_idx];
end

// same counter value for colour and syncs, so they stay aligned
always_ff @(posedge clk)
begin
  if (rst)
  begin
    rgb   <= '0;
    hsync <= 1'b1;
    vsync <= 1'b1;
  end
  else
  begin
    rgb   <= color;
    hsync <= hsync_raw;
    vsync <= vsync_raw;
  end
end

endmodule

`default_nettype wire

// ==== src/ppu_top.sv ====
// top of the ppu background path
// scan timer, cpu register interface, tile fetcher, palette stage
`default_nettype none

module ppu_top
(
  input  wire                   clk,
  input  wire                   rst,
  input  wire ppu_pkg::ri_bus_t ri,
  input  wire [7:0]             vram_din,
  output wire [7:0]             ri_dout,
  output wire [13:0]            vram_a,
  output wire [7:0]             vram_dout,
  output wire                   vram_wr,
  output wire                   nvbl,      // low in vblank when enabled
  output wire                   hsync,
  output wire                   vsync,
  output wire ppu_pkg::rgb_t    rgb
);

wire ppu_pkg::scan_pos_t pos;
wire                     hsync_raw;
wire                     vsync_raw;
wire ppu_pkg::ppu_ctrl_t ctrl;
wire ppu_pkg::vram_req_t bg_req;    // display claim on the bus
wire ppu_pkg::pal_port_t pal;
wire [5:0]               pal_rdata;
wire ppu_pkg::bg_pixel_t pixel;

ppu_scan_timing u_scan (
  .clk       (clk),
  .rst       (rst),
  .pos       (pos),
  .hsync_raw (hsync_raw),
  .vsync_raw (vsync_raw)
);

ppu_reg_if u_reg_if (
  .clk       (clk),
  .rst       (rst),
  .ri        (ri),
  .pos       (pos),
  .bg_req    (bg_req),
  .vram_din  (vram_din),
  .pal_rdata (pal_rdata),
  .ctrl      (ctrl),
  .pal       (pal),
  .ri_dout   (ri_dout),
  .vram_a    (vram_a),
  .vram_dout (vram_dout),
  .vram_wr   (vram_wr),
  .nvbl      (nvbl)
);

ppu_bg_fetch u_bg_fetch (
  .clk       (clk),
  .rst       (rst),
  .pos       (pos),
  .ctrl      (ctrl),
  .vram_din  (vram_din),
  .bg_req    (bg_req),
  .pixel     (pixel)
);

ppu_palette u_palette (
  .clk       (clk),
  .rst       (rst),
  .pos       (pos),
  .pixel     (pixel),
  .pal       (pal),
  .hsync_raw (hsync_raw),
  .vsync_raw (vsync_raw),
  .pal_rdata (pal_rdata),
  .rgb       (rgb),
  .hsync     (hsync),
  .vsync     (vsync)
);

endmodule

`default_nettype wire

// ==== testbench/tb_ppu.sv ====
// testbench for the ppu background path
// clock, reset, 16k vram model, cpu bus tasks
// directed tests for registers, palette, vblank and picture colour
// watchdog sized from the frame length
`default_nettype none
`include "ppu_settings.svh"

module tb_ppu;

localparam int frame_cycles = `PPU_H_TOTAL * `PPU_V_TOTAL;
// vblank polling spans one frame, the colour test may wait a frame for vsync then counts one
localparam int budget_cycles = 3 * frame_cycles + 20000;

logic               clk;
logic               rst;
ppu_pkg::ri_bus_t   ri;
wire  [7:0]         vram_din;
wire  [7:0]         ri_dout;
wire  [13:0]        vram_a;
wire  [7:0]         vram_dout;
wire                vram_wr;
wire                nvbl;
wire                hsync;
wire                vsync;
wire ppu_pkg::rgb_t rgb;

logic [7:0] vram [16384];   // 16k byte vram model
logic       nvbl_at_cs;     // nvbl seen when ncs went low

ppu_top u_dut (
  .clk       (clk),
  .rst       (rst),
  .ri        (ri),
  .vram_din  (vram_din),
  .ri_dout   (ri_dout),
  .vram_a    (vram_a),
  .vram_dout (vram_dout),
  .vram_wr   (vram_wr),
  .nvbl      (nvbl),
  .hsync     (hsync),
  .vsync     (vsync),
  .rgb       (rgb)
);

assign vram_din = vram[vram_a];   // combinational read

always @(posedge clk)
begin
  if (vram_wr)
    vram[vram_a] <= vram_dout;
end

initial
begin
  clk = 1'b0;
  forever #5 clk = ~clk;
end

initial
begin
  repeat (budget_cycles) @(posedge clk);
  $display("timeout: the tests did not finish within %0d cycles", budget_cycles);
  report_fail();
end

//////////////////////////////
// helpers
//////////////////////////////
task automatic report_fail();
  $display("Simulation finished: FAIL");
  $fatal(1, "run stopped at the first error");
endtask

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
  assert (got === exp) else
  begin
    $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    report_fail();
  end
endtask

task automatic idle_cycles(input int n);
  repeat (n) @(negedge clk);
endtask

// one access per ncs low phase, inputs move on the falling edge
task automatic cpu_write(input logic [2:0] sel, input logic [7:0] data);
  @(negedge clk);
  ri.sel  = sel;
  ri.r_nw = 1'b0;
  ri.din  = data;
  ri.ncs  = 1'b0;
  @(negedge clk);
  ri.ncs  = 1'b1;
  ri.r_nw = 1'b1;
endtask

task automatic cpu_read(input logic [2:0] sel, output logic [7:0] data);
  @(negedge clk);
  nvbl_at_cs = nvbl;
  ri.sel     = sel;
  ri.r_nw    = 1'b1;
  ri.ncs     = 1'b0;
  @(negedge clk);
  data   = ri_dout;   // latch is valid one cycle after the edge
  ri.ncs = 1'b1;
endtask

// pulse may already be up when cpu_write returns
task automatic expect_vram_write(input logic [13:0] addr, input logic [7:0] data);
  int n;
  n = 0;
  while (!vram_wr && n < 32)
  begin
    @(negedge clk);
    n++;
  end
  if (!vram_wr)
  begin
    $display("no vram write pulse within 32 cycles of the 0x2007 write");
    report_fail();
  end
  check_value("vram_a on write", vram_a, addr);
  check_value("vram_dout on write", vram_dout, data);
  @(negedge clk);
  check_value("vram_wr after the pulse", vram_wr, 1'b0);   // single cycle
  idle_cycles(16);
endtask

//////////////////////////////
// directed tests
//////////////////////////////
task automatic reset_state();
  repeat (8)
  begin
    check_value("nvbl after reset", nvbl, 1'b1);
    check_value("vram_wr after reset", vram_wr, 1'b0);
    check_value("ri_dout after reset", ri_dout, 8'h00);
    @(negedge clk);
  end
endtask

task automatic vram_write_steps();
  cpu_write(3'h6, 8'h21);   // high byte first
  cpu_write(3'h6, 8'h08);
  cpu_write(3'h7, 8'h11);
  expect_vram_write(14'h2108, 8'h11);
  cpu_write(3'h7, 8'h22);
  expect_vram_write(14'h2109, 8'h22);
  cpu_write(3'h0, 8'h04);   // step 32
  cpu_write(3'h7, 8'h33);
  expect_vram_write(14'h210A, 8'h33);
  cpu_write(3'h7, 8'h44);
  expect_vram_write(14'h212A, 8'h44);
  check_value("vram model at 0x212a", vram[14'h212A], 8'h44);
  cpu_write(3'h0, 8'h00);   // back to step 1
endtask

task automatic buffered_read();
  logic [7:0] d;
  vram[14'h2300] = 8'h5A;
  vram[14'h2301] = 8'hA5;
  cpu_write(3'h6, 8'h23);
  cpu_write(3'h6, 8'h00);
  cpu_read(3'h7, d);        // stale buffer, starts the fetch
  idle_cycles(16);
  cpu_read(3'h7, d);
  check_value("first buffered read", d, 8'h5A);
  idle_cycles(16);
  check_value("address after second read", vram_a, 14'h2301);
  cpu_read(3'h7, d);
  check_value("second buffered read", d, 8'hA5);
  idle_cycles(16);
endtask

task automatic palette_access();
  logic [7:0] d;
  cpu_write(3'h6, 8'h3F);
  cpu_write(3'h6, 8'h03);
  cpu_write(3'h7, 8'hD6);
  repeat (16)
  begin
    check_value("vram_wr on palette write", vram_wr, 1'b0);
    @(negedge clk);
  end
  cpu_write(3'h6, 8'h3F);
  cpu_write(3'h6, 8'h03);
  cpu_read(3'h7, d);
  idle_cycles(16);
  cpu_read(3'h7, d);
  check_value("palette read-back", d, 8'h16);   // top two bits dropped
  idle_cycles(16);
endtask

// 4200 polls 100 cycles apart span exactly one frame
task automatic vblank_status();
  logic [7:0] d;
  logic       prev;
  int         rises;
  int         falls;
  rises = 0;
  falls = 0;
  cpu_write(3'h0, 8'h80);   // nvbl_en
  cpu_read(3'h2, d);
  prev = d[7];
  repeat (frame_cycles / 100)
  begin
    idle_cycles(98);
    cpu_read(3'h2, d);
    check_value("status bit 7 against nvbl", d[7], !nvbl_at_cs);
    check_value("status low bits", d[6:0], 7'h00);
    if (d[7] && !prev)
      rises++;
    if (!d[7] && prev)
      falls++;
    prev = d[7];
  end
  check_value("vblank starts per frame", rises, 1);
  check_value("vblank ends per frame", falls, 1);
endtask

task automatic picture_colour();
  int          n;
  int          h;
  int          v;
  int          red_count;
  logic        vs_prev;
  logic        in_pic;
  logic [11:0] exp;
  for (int a = 0; a < 16'h2000; a++)
    vram[a] = 8'hFF;           // every pattern plane solid
  for (int a = 16'h23C0; a < 16'h2400; a++)
    vram[a] = 8'h00;           // attribute 0 everywhere
  cpu_write(3'h6, 8'h3F);
  cpu_write(3'h6, 8'h03);
  cpu_write(3'h7, 8'h16);      // palette entry 3
  idle_cycles(16);
  cpu_write(3'h1, 8'h08);      // bg_en
  n = 0;
  vs_prev = vsync;
  @(negedge clk);
  while (!(vs_prev && !vsync) && n < frame_cycles)
  begin
    vs_prev = vsync;
    @(negedge clk);
    n++;
  end
  if (!(vs_prev && !vsync))
  begin
    $display("vsync never fell within one frame");
    report_fail();
  end
  // first low vsync sample carries line VSYNC_START, clock 0
  h = 0;
  v = `PPU_VSYNC_START;
  red_count = 0;
  repeat (frame_cycles)
  begin
    in_pic = (h >= `PPU_NES_X_OFS) && (h < `PPU_NES_X_OFS + `PPU_NES_W) &&
             (v >= `PPU_NES_Y_OFS) && (v < `PPU_NES_Y_OFS + `PPU_NES_H);
    if (!(h < `PPU_DISPLAY_W && v < `PPU_DISPLAY_H))
      exp = 12'h000;
    else if (in_pic)
      exp = 12'hF20;           // system colour 0x16
    else
      exp = `PPU_BORDER_RGB;
    assert (rgb === exp) else
    begin
      $display("ERR %0t: rgb %h at h=%0d v=%0d, expected %h", $time, rgb, h, v, exp);
      report_fail();
    end
    assert ((hsync === !(h >= `PPU_HSYNC_START && h < `PPU_HSYNC_END)) &&
            (vsync === !(v >= `PPU_VSYNC_START && v < `PPU_VSYNC_END))) else
    begin
      $display("ERR %0t: syncs %b%b out of line with h=%0d v=%0d", $time, hsync, vsync, h, v);
      report_fail();
    end
    if (rgb === 12'hF20)
      red_count++;
    vs_prev = vsync;
    h = (h == `PPU_H_TOTAL - 1) ? 0 : h + 1;
    if (h == 0)
      v = (v == `PPU_V_TOTAL - 1) ? 0 : v + 1;
    @(negedge clk);
  end
  check_value("vsync fall after one frame", {vs_prev, vsync}, 2'b10);
  check_value("f20 samples in the frame", red_count, 61440);
endtask

//////////////////////////////
// main sequence
//////////////////////////////
initial
begin
  rst     = 1'b1;
  ri.sel  = 3'h0;
  ri.ncs  = 1'b1;
  ri.r_nw = 1'b1;
  ri.din  = 8'h00;
  for (int a = 0; a < 16384; a++)
    vram[a] = a[7:0] ^ {2'b00, a[13:8]};   // low byte xor high bits
  repeat (4) @(posedge clk);
  @(negedge clk);
  rst = 1'b0;
  reset_state();
  vram_write_steps();
  buffered_read();
  palette_access();
  vblank_status();
  picture_colour();
  $display("Simulation finished: PASS");
  $finish;
end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+src
src/ppu_pkg.sv
src/ppu_scan_timing.sv
src/ppu_reg_if.sv
src/ppu_bg_fetch.sv
src/ppu_palette.sv
src/ppu_top.sv
testbench/tb_ppu.sv
